//--- design/sd_macros.svh
`ifndef SD_MACROS_SVH
`define SD_MACROS_SVH

// one data block, in bytes, and the width of a byte index into it
`define SD_BLOCK_BYTES 512
`define SD_ADDR_BITS 9

// command and response frames have the same length
`define SD_CMD_BITS 48
`define SD_CRC7_BITS 7

// frame bits covered by the crc7: everything ahead of the crc and end bit
`define SD_HDR_BITS (`SD_CMD_BITS - `SD_CRC7_BITS - 1)

`define SD_CRC16_BITS 16

`endif

//--- design/sd_bus_pkg.sv
`default_nettype none

`include "sd_macros.svh"

package sd_bus_pkg;

    // command line sequencer
    typedef enum logic [2:0] {
        CMD_IDLE,
        CMD_LOAD,
        CMD_CRC,
        CMD_TXCMD,
        CMD_RXCMD
    } sd_cmd_state_e;

    // data line receiver
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_DATA,
        RX_CRC,
        RX_DONE
    } sd_rx_state_e;

    // byte from the data line, tagged with its position in the block
    typedef struct packed {
        logic [`SD_ADDR_BITS-1:0] idx;
        logic [7:0]               data;
    } sd_byte_t;

    // command frame as it goes out on the line, start bit first
    typedef struct packed {
        logic                     start;
        logic                     trans;
        logic [5:0]               index;
        logic [31:0]              arg;
        logic [`SD_CRC7_BITS-1:0] crc;
        logic                     stop;
    } sd_cmd_frame_t;

endpackage

`default_nettype wire

//--- design/sd_host_pkg.sv
`default_nettype none

package sd_host_pkg;

    // cpu register map
    typedef enum logic [2:0] {
        ARG0       = 3'd0,
        ARG1       = 3'd1,
        ARG2       = 3'd2,
        ARG3       = 3'd3,
        CMD_STATUS = 3'd4,
        DATA       = 3'd5
    } sd_reg_addr_e;

    // status byte, resp_ready lands in bit 0
    typedef struct packed {
        logic [3:0] rsvd;
        logic       busy;
        logic       crc_err;
        logic       data_ready;
        logic       resp_ready;
    } sd_status_t;

endpackage

`default_nettype wire

//--- design/sd_crc7.sv
`default_nettype none

`include "sd_macros.svh"

module sd_crc7 (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            i_load,
    input  wire  [`SD_HDR_BITS-1:0]        i_header,
    output logic [`SD_CRC7_BITS-1:0]       o_crc,
    output logic                           o_valid
);

    localparam int CNT_W = $clog2(`SD_HDR_BITS);

    logic [`SD_HDR_BITS-1:0] shreg;
    logic [CNT_W-1:0]        count;
    logic                    running;
    logic                    fb;

    // x^7 + x^3 + 1, header msb first
    assign fb = o_crc[`SD_CRC7_BITS-1] ^ shreg[`SD_HDR_BITS-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            o_valid <= 1'b0;
            count   <= '0;
        end else if (i_load) begin
            running <= 1'b1;
            o_valid <= 1'b0;
            count   <= '0;
        end else if (running) begin
            count <= count + 1'b1;
            if (count == CNT_W'(`SD_HDR_BITS - 1)) begin
                running <= 1'b0;
                o_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_load) begin
            shreg <= i_header;
            o_crc <= '0;
        end else if (running) begin
            shreg <= {shreg[`SD_HDR_BITS-2:0], 1'b0};
            o_crc <= {o_crc[`SD_CRC7_BITS-2:0], 1'b0} ^ ({`SD_CRC7_BITS{fb}} & 7'h09);
        end
    end

    // the sequencer must wait for o_valid before loading the next header
    a_no_reload: assert property (@(posedge clk) disable iff (rst) i_load |-> !running)
        else $error("crc7 reloaded while running");

endmodule

`default_nettype wire

//--- design/sd_controller.sv
`default_nettype none

`include "sd_macros.svh"

module sd_controller (
    input  wire                       clk,
    input  wire                       rst,

    input  wire                       i_sd_clk,
    input  wire                       i_sd_cmd,
    output logic                      o_sd_cmd,

    input  wire sd_host_pkg::sd_reg_addr_e i_addr,
    input  wire  [7:0]                i_data,
    input  wire                       i_cs,
    input  wire                       i_rw,
    output logic [7:0]                o_data_out,

    input  wire                       i_block_done,
    input  wire                       i_crc_err,

    output logic                      o_rd_pop,
    input  wire  [7:0]                i_rd_byte
);

    localparam int CNT_W = $clog2(`SD_CMD_BITS);
    localparam int LAST  = `SD_CMD_BITS - 1;

    sd_bus_pkg::sd_cmd_state_e state;
    sd_bus_pkg::sd_cmd_frame_t frame_q;
    sd_host_pkg::sd_status_t   status;

    logic [CNT_W-1:0]           count;
    logic [31:0]                arg;
    logic [`SD_CMD_BITS-1:0]    resp;
    logic                       resp_ready;
    logic                       data_ready;
    logic                       crc_err;

    logic                       sd_clk_q;
    logic                       tx_en;
    logic                       rx_en;
    logic                       wr;
    logic                       rd;
    logic                       cmd_wr;
    logic                       rx_shift;
    logic [`SD_CRC7_BITS-1:0]   crc7;
    logic                       crc_valid;

    // transmit once per high sd_clk phase and sample once per low phase
    assign tx_en = i_sd_clk & ~sd_clk_q;
    assign rx_en = ~i_sd_clk & sd_clk_q;

    assign wr     = i_cs & ~i_rw;
    assign rd     = i_cs & i_rw;
    assign cmd_wr = wr && i_addr == sd_host_pkg::CMD_STATUS && state == sd_bus_pkg::CMD_IDLE;

    // the start bit is taken on the way into RXCMD
    assign rx_shift = rx_en && (state == sd_bus_pkg::CMD_RXCMD ||
                      (state == sd_bus_pkg::CMD_IDLE && !i_sd_cmd && !cmd_wr));

    assign o_rd_pop = rd && i_addr == sd_host_pkg::DATA;

    always_comb begin
        status            = '0;
        status.resp_ready = resp_ready;
        status.data_ready = data_ready;
        status.crc_err    = crc_err;
        status.busy       = state != sd_bus_pkg::CMD_IDLE;
    end

    always_comb begin
        o_data_out = '0;
        case (i_addr)
            sd_host_pkg::ARG0, sd_host_pkg::ARG1, sd_host_pkg::ARG2, sd_host_pkg::ARG3:
                o_data_out = resp[8 + 8 * i_addr[1:0] +: 8];
            sd_host_pkg::CMD_STATUS: o_data_out = status;
            sd_host_pkg::DATA:       o_data_out = i_rd_byte;
            default: ;
        endcase
    end

    assign o_sd_cmd = (state == sd_bus_pkg::CMD_TXCMD) ? frame_q[LAST - count] : 1'b1;

    sd_crc7 crc7_i (
        .clk      (clk),
        .rst      (rst),
        .i_load   (state == sd_bus_pkg::CMD_LOAD),
        .i_header (frame_q[`SD_CMD_BITS-1 -: `SD_HDR_BITS]),
        .o_crc    (crc7),
        .o_valid  (crc_valid)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= sd_bus_pkg::CMD_IDLE;
            count      <= '0;
            resp_ready <= 1'b0;
            data_ready <= 1'b0;
            crc_err    <= 1'b0;
            sd_clk_q   <= 1'b0;
        end else begin
            sd_clk_q <= i_sd_clk;

            // a status read clears the flag unless a response finishes on the same clk
            if (rd && i_addr == sd_host_pkg::CMD_STATUS) begin
                resp_ready <= 1'b0;
            end

            case (state)
                sd_bus_pkg::CMD_IDLE: begin
                    if (cmd_wr) begin
                        state <= sd_bus_pkg::CMD_LOAD;
                    end else if (rx_shift) begin
                        state <= sd_bus_pkg::CMD_RXCMD;
                        count <= CNT_W'(1);
                    end
                end
                sd_bus_pkg::CMD_LOAD: state <= sd_bus_pkg::CMD_CRC;
                sd_bus_pkg::CMD_CRC: begin
                    if (crc_valid) begin
                        state <= sd_bus_pkg::CMD_TXCMD;
                        count <= '0;
                    end
                end
                sd_bus_pkg::CMD_TXCMD: begin
                    if (tx_en) begin
                        if (count == CNT_W'(LAST)) begin
                            state <= sd_bus_pkg::CMD_IDLE;
                            count <= '0;
                        end else begin
                            count <= count + 1'b1;
                        end
                    end
                end
                sd_bus_pkg::CMD_RXCMD: begin
                    if (rx_en) begin
                        if (count == CNT_W'(LAST)) begin
                            state      <= sd_bus_pkg::CMD_IDLE;
                            count      <= '0;
                            resp_ready <= 1'b1;
                        end else begin
                            count <= count + 1'b1;
                        end
                    end
                end
                default: state <= sd_bus_pkg::CMD_IDLE;
            endcase

            if (i_block_done) begin
                data_ready <= 1'b1;
                crc_err    <= i_crc_err;
            end else if (o_rd_pop) begin
                data_ready <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr && i_addr <= sd_host_pkg::ARG3) begin
            arg[8 * i_addr[1:0] +: 8] <= i_data;
        end
        // the frame is frozen here so later ARG writes do not disturb a transmit
        if (cmd_wr) begin
            frame_q.start <= 1'b0;
            frame_q.trans <= 1'b1;
            frame_q.index <= i_data[5:0];
            frame_q.arg   <= arg;
            frame_q.crc   <= '0;
            frame_q.stop  <= 1'b1;
        end
        if (state == sd_bus_pkg::CMD_CRC && crc_valid) begin
            frame_q.crc <= crc7;
        end
        if (rx_shift) begin
            resp <= {resp[`SD_CMD_BITS-2:0], i_sd_cmd};
        end
    end

endmodule

`default_nettype wire

//--- design/sd_data_rx.sv
`default_nettype none

`include "sd_macros.svh"

module sd_data_rx (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 i_sd_clk,
    input  wire                 i_sd_data,

    output sd_bus_pkg::sd_byte_t o_rx_byte,
    output logic                o_rx_req,
    input  wire                 i_rx_ack,

    output logic                o_block_start,
    output logic                o_block_done,
    output logic                o_crc_err
);

    // bit counter, byte index on top of a 3-bit bit position
    localparam int CNT_W = `SD_ADDR_BITS + 3;

    sd_bus_pkg::sd_rx_state_e state;

    logic [CNT_W-1:0]              count;
    logic [6:0]                    shreg;
    logic [`SD_CRC16_BITS-1:0]     crc_calc;
    logic [`SD_CRC16_BITS-1:0]     crc_rx;
    logic                          sd_clk_q;
    logic                          rx_en;
    logic                          start;
    logic                          byte_done;
    logic                          fb;

    assign rx_en     = ~i_sd_clk & sd_clk_q;
    assign start     = state == sd_bus_pkg::RX_IDLE && rx_en && !i_sd_data;
    assign byte_done = state == sd_bus_pkg::RX_DATA && rx_en && count[2:0] == 3'd7;

    // x^16 + x^12 + x^5 + 1
    assign fb = crc_calc[`SD_CRC16_BITS-1] ^ i_sd_data;

    assign o_block_done = state == sd_bus_pkg::RX_DONE;
    assign o_crc_err    = o_block_done && crc_rx != crc_calc;

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= sd_bus_pkg::RX_IDLE;
            count         <= '0;
            o_rx_req      <= 1'b0;
            o_block_start <= 1'b0;
            sd_clk_q      <= 1'b0;
        end else begin
            sd_clk_q      <= i_sd_clk;
            o_block_start <= start;

            if (byte_done) begin
                o_rx_req <= 1'b1;
            end else if (i_rx_ack) begin
                o_rx_req <= 1'b0;
            end

            case (state)
                sd_bus_pkg::RX_IDLE: begin
                    if (start) begin
                        state <= sd_bus_pkg::RX_DATA;
                        count <= '0;
                    end
                end
                sd_bus_pkg::RX_DATA: begin
                    if (rx_en) begin
                        // wraps to zero after the last data bit
                        count <= count + 1'b1;
                        if (&count) begin
                            state <= sd_bus_pkg::RX_CRC;
                        end
                    end
                end
                sd_bus_pkg::RX_CRC: begin
                    if (rx_en) begin
                        count <= count + 1'b1;
                        if (count == CNT_W'(`SD_CRC16_BITS - 1)) begin
                            state <= sd_bus_pkg::RX_DONE;
                            count <= '0;
                        end
                    end
                end
                default: state <= sd_bus_pkg::RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            crc_calc <= '0;
        end else if (state == sd_bus_pkg::RX_DATA && rx_en) begin
            shreg    <= {shreg[5:0], i_sd_data};
            crc_calc <= {crc_calc[`SD_CRC16_BITS-2:0], 1'b0} ^
                        ({`SD_CRC16_BITS{fb}} & 16'h1021);
        end
        if (state == sd_bus_pkg::RX_CRC && rx_en) begin
            crc_rx <= {crc_rx[`SD_CRC16_BITS-2:0], i_sd_data};
        end
        // msb arrives first, the current bit completes the byte
        if (byte_done) begin
            o_rx_byte.idx  <= count[CNT_W-1:3];
            o_rx_byte.data <= {shreg, i_sd_data};
        end
    end

    // the buffer has to finish the handshake before the next byte is complete
    a_no_overrun: assert property (@(posedge clk) disable iff (rst) byte_done |-> !o_rx_req)
        else $error("rx byte overrun, handshake still open");

endmodule

`default_nettype wire

//--- design/sd_rx_buffer.sv
`default_nettype none

`include "sd_macros.svh"

module sd_rx_buffer (
    input  wire                  clk,
    input  wire                  rst,

    input  wire sd_bus_pkg::sd_byte_t i_rx_byte,
    input  wire                  i_rx_req,
    output logic                 o_rx_ack,

    input  wire                  i_block_start,

    input  wire                  i_rd_pop,
    output logic [7:0]           o_rd_byte
);

    logic [7:0]               mem [`SD_BLOCK_BYTES];
    logic [`SD_ADDR_BITS-1:0] rd_ptr;

    // store once per request, on the cycle before ack goes up
    always_ff @(posedge clk) begin
        if (i_rx_req && !o_rx_ack) begin
            mem[i_rx_byte.idx] <= i_rx_byte.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_rx_ack <= 1'b0;
            rd_ptr   <= '0;
        end else begin
            o_rx_ack <= i_rx_req;
            if (i_block_start) begin
                rd_ptr <= '0;
            end else if (i_rd_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    assign o_rd_byte = mem[rd_ptr];

    // the producer holds req up until it has seen ack
    a_ack_with_req: assert property (@(posedge clk) disable iff (rst)
        $rose(o_rx_ack) |-> i_rx_req)
        else $error("rx ack raised without a request");

endmodule

`default_nettype wire

//--- design/sd_host_top.sv
`default_nettype none

module sd_host_top (
    input  wire                       clk,
    input  wire                       rst,

    input  wire                       i_sd_clk,
    input  wire                       i_sd_cmd,
    output logic                      o_sd_cmd,
    input  wire                       i_sd_data,
    output logic                      o_sd_data,

    input  wire sd_host_pkg::sd_reg_addr_e i_addr,
    input  wire  [7:0]                i_data,
    input  wire                       i_cs,
    input  wire                       i_rw,
    output logic [7:0]                o_data_out
);

    sd_bus_pkg::sd_byte_t rx_byte;
    logic                 rx_req;
    logic                 rx_ack;
    logic                 block_start;
    logic                 block_done;
    logic                 crc_err;
    logic                 rd_pop;
    logic [7:0]           rd_byte;

    // host never drives the data line
    assign o_sd_data = 1'b1;

    sd_controller ctrl_i (
        .clk          (clk),
        .rst          (rst),
        .i_sd_clk     (i_sd_clk),
        .i_sd_cmd     (i_sd_cmd),
        .o_sd_cmd     (o_sd_cmd),
        .i_addr       (i_addr),
        .i_data       (i_data),
        .i_cs         (i_cs),
        .i_rw         (i_rw),
        .o_data_out   (o_data_out),
        .i_block_done (block_done),
        .i_crc_err    (crc_err),
        .o_rd_pop     (rd_pop),
        .i_rd_byte    (rd_byte)
    );

    sd_data_rx data_rx_i (
        .clk           (clk),
        .rst           (rst),
        .i_sd_clk      (i_sd_clk),
        .i_sd_data     (i_sd_data),
        .o_rx_byte     (rx_byte),
        .o_rx_req      (rx_req),
        .i_rx_ack      (rx_ack),
        .o_block_start (block_start),
        .o_block_done  (block_done),
        .o_crc_err     (crc_err)
    );

    sd_rx_buffer rx_buf_i (
        .clk           (clk),
        .rst           (rst),
        .i_rx_byte     (rx_byte),
        .i_rx_req      (rx_req),
        .o_rx_ack      (rx_ack),
        .i_block_start (block_start),
        .i_rd_pop      (rd_pop),
        .o_rd_byte     (rd_byte)
    );

endmodule

`default_nettype wire

//--- tb/sd_card_model.sv
`default_nettype none

`include "sd_macros.svh"

module sd_card_model (
    input  wire                        i_sd_clk,
    input  wire                        i_cmd,
    output logic                       o_cmd,
    output logic                       o_data,
    input  wire                        i_resp_req,
    input  wire  [31:0]                i_resp_field,
    input  wire                        i_block_req,
    input  wire                        i_flip_crc,
    input  wire  [7:0]                 i_block [`SD_BLOCK_BYTES],
    output sd_bus_pkg::sd_cmd_frame_t  o_frame,
    output logic [6:0]                 o_frame_crc,
    output int                         o_frame_count,
    output int                         o_sent_count
);

    // x^7 + x^3 + 1 over the header, msb first
    function automatic logic [6:0] calc_crc7(input logic [39:0] hdr);
        logic [6:0] crc;
        logic       fb;
        int         i;
        crc = '0;
        for (i = 39; i >= 0; i--) begin
            fb  = crc[6] ^ hdr[i];
            crc = {crc[5:0], 1'b0};
            if (fb) begin
                crc = crc ^ 7'h09;
            end
        end
        return crc;
    endfunction

    // x^16 + x^12 + x^5 + 1 over the whole block, msb of each byte first
    function automatic logic [15:0] calc_crc16();
        logic [15:0] crc;
        logic        fb;
        int          i;
        int          b;
        crc = '0;
        for (i = 0; i < `SD_BLOCK_BYTES; i++) begin
            for (b = 7; b >= 0; b--) begin
                fb  = crc[15] ^ i_block[i][b];
                crc = {crc[14:0], 1'b0};
                if (fb) begin
                    crc = crc ^ 16'h1021;
                end
            end
        end
        return crc;
    endfunction

    task automatic drive_response(input logic [31:0] field);
        logic [47:0] frm;
        int          i;
        frm      = {2'b00, o_frame.index, field, 7'h00, 1'b1};
        frm[7:1] = calc_crc7(frm[47:8]);
        for (i = 47; i >= 0; i--) begin
            o_cmd = frm[i];
            @(posedge i_sd_clk);
        end
        o_cmd = 1'b1;
    endtask

    task automatic drive_block();
        logic [15:0] crc;
        int          i;
        int          b;
        crc = calc_crc16();
        if (i_flip_crc) begin
            crc[0] = ~crc[0];
        end
        o_data = 1'b0;
        @(posedge i_sd_clk);
        for (i = 0; i < `SD_BLOCK_BYTES; i++) begin
            for (b = 7; b >= 0; b--) begin
                o_data = i_block[i][b];
                @(posedge i_sd_clk);
            end
        end
        for (b = 15; b >= 0; b--) begin
            o_data = crc[b];
            @(posedge i_sd_clk);
        end
        // end bit, line then stays high
        o_data = 1'b1;
    endtask

    // a low command line at an sd_clk rise is the start bit of a frame
    initial begin : capture_frames
        logic [47:0] shift;
        int          n;
        o_frame       = '0;
        o_frame_crc   = '0;
        o_frame_count = 0;
        forever begin
            @(posedge i_sd_clk);
            if (!i_cmd) begin
                shift = '0;
                for (n = 1; n < `SD_CMD_BITS; n++) begin
                    @(posedge i_sd_clk);
                    shift = {shift[46:0], i_cmd};
                end
                o_frame     = shift;
                o_frame_crc = calc_crc7(shift[47:8]);
                o_frame_count++;
            end
        end
    end

    initial begin : serve_requests
        o_cmd        = 1'b1;
        o_data       = 1'b1;
        o_sent_count = 0;
        forever begin
            @(posedge i_sd_clk);
            if (i_resp_req) begin
                drive_response(i_resp_field);
                o_sent_count++;
            end else if (i_block_req) begin
                drive_block();
                o_sent_count++;
            end
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_sd_host_top.sv
`default_nettype none

`include "sd_macros.svh"

module tb_sd_host_top;

    logic                      clk;
    logic                      rst;
    logic                      sd_clk;
    logic [1:0]                div;
    logic                      host_cmd;
    logic                      card_cmd;
    logic                      card_data;
    logic                      host_data;
    sd_host_pkg::sd_reg_addr_e addr;
    logic [7:0]                wdata;
    logic [7:0]                rdata;
    logic                      cs;
    logic                      rw;

    logic                      resp_req;
    logic                      block_req;
    logic                      flip_crc;
    logic [31:0]               resp_field;
    logic [7:0]                blk [`SD_BLOCK_BYTES];
    sd_bus_pkg::sd_cmd_frame_t frame;
    logic [6:0]                frame_crc;
    int                        frame_count;
    int                        sent_count;
    sd_host_pkg::sd_status_t   status;

    int                        errors;
    int                        checks;
    int                        seed;
    logic                      chk_en;
    int                        chk_id;
    string                     chk_name;
    logic [31:0]               chk_exp;
    logic [31:0]               chk_act;

    sd_host_top dut_i (
        .clk        (clk),
        .rst        (rst),
        .i_sd_clk   (sd_clk),
        .i_sd_cmd   (card_cmd),
        .o_sd_cmd   (host_cmd),
        .i_sd_data  (card_data),
        .o_sd_data  (host_data),
        .i_addr     (addr),
        .i_data     (wdata),
        .i_cs       (cs),
        .i_rw       (rw),
        .o_data_out (rdata)
    );

    sd_card_model card_i (
        .i_sd_clk      (sd_clk),
        .i_cmd         (host_cmd),
        .o_cmd         (card_cmd),
        .o_data        (card_data),
        .i_resp_req    (resp_req),
        .i_resp_field  (resp_field),
        .i_block_req   (block_req),
        .i_flip_crc    (flip_crc),
        .i_block       (blk),
        .o_frame       (frame),
        .o_frame_crc   (frame_crc),
        .o_frame_count (frame_count),
        .o_sent_count  (sent_count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // sd_clk is clk / 4 and moves just after the clk edge like all stimulus
    initial begin
        sd_clk = 1'b0;
        div    = '0;
        forever begin
            @(posedge clk);
            #1;
            div    = div + 2'd1;
            sd_clk = div[1];
        end
    end

    function automatic void report_mismatch();
        errors++;
        $display("error %s: expected %0h, actual %0h", chk_name, chk_exp, chk_act);
    endfunction

    a_reset_state: assert property (@(posedge clk) disable iff (rst)
        chk_en && chk_id == 1 |-> chk_act == chk_exp)
        else report_mismatch();

    a_cmd_frame: assert property (@(posedge clk) disable iff (rst)
        chk_en && chk_id == 2 |-> chk_act == chk_exp)
        else report_mismatch();

    a_response: assert property (@(posedge clk) disable iff (rst)
        chk_en && chk_id == 3 |-> chk_act == chk_exp)
        else report_mismatch();

    a_block_data: assert property (@(posedge clk) disable iff (rst)
        chk_en && chk_id == 4 |-> chk_act == chk_exp)
        else report_mismatch();

    a_block_crc_err: assert property (@(posedge clk) disable iff (rst)
        chk_en && chk_id == 5 |-> chk_act == chk_exp)
        else report_mismatch();

    a_busy_ignore: assert property (@(posedge clk) disable iff (rst)
        chk_en && chk_id == 6 |-> chk_act == chk_exp)
        else report_mismatch();

    a_data_line_high: assert property (@(posedge clk) disable iff (rst) host_data)
        else begin
            errors++;
            $display("host pulled the data line low");
        end

    // every task starts and ends one time unit after a rising clk edge
    task automatic cpu_write(input sd_host_pkg::sd_reg_addr_e a, input logic [7:0] d);
        addr  = a;
        wdata = d;
        rw    = 1'b0;
        cs    = 1'b1;
        @(posedge clk);
        #1;
        cs = 1'b0;
    endtask

    task automatic cpu_read(input sd_host_pkg::sd_reg_addr_e a, output logic [7:0] d);
        addr = a;
        rw   = 1'b1;
        cs   = 1'b1;
        #2;
        d = rdata;
        @(posedge clk);
        #1;
        cs = 1'b0;
        rw = 1'b0;
    endtask

    task automatic expect_equal(input int id, input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        chk_id   = id;
        chk_name = name;
        chk_exp  = exp;
        chk_act  = act;
        chk_en   = 1'b1;
        checks++;
        @(posedge clk);
        #1;
        chk_en = 1'b0;
    endtask

    task automatic wait_status_bit(input int bit_idx, input logic level, input string what,
                                   input int limit);
        logic [7:0] d;
        int         n;
        n = 0;
        cpu_read(sd_host_pkg::CMD_STATUS, d);
        while (d[bit_idx] != level && n < limit) begin
            cpu_read(sd_host_pkg::CMD_STATUS, d);
            n++;
        end
        status = d;
        if (d[bit_idx] != level) begin
            errors++;
            $display("timeout waiting for %s", what);
        end
    endtask

    task automatic wait_frame(input int base, input int limit);
        int n;
        n = 0;
        while (frame_count == base && n < limit) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (frame_count == base) begin
            errors++;
            $display("timeout waiting for a command frame from the host");
        end
    endtask

    // hold the request until the card reports the transfer as sent
    task automatic card_transfer(input logic is_block, input int limit);
        int base;
        int n;
        base = sent_count;
        n    = 0;
        if (is_block) begin
            block_req = 1'b1;
        end else begin
            resp_req = 1'b1;
        end
        while (sent_count == base && n < limit) begin
            @(posedge clk);
            #1;
            n++;
        end
        resp_req  = 1'b0;
        block_req = 1'b0;
        if (sent_count == base) begin
            errors++;
            $display("timeout waiting for the card to finish sending");
        end
    endtask

    initial begin : run_tests
        logic [31:0] arg;
        logic [5:0]  idx;
        logic [7:0]  d;
        int          base;
        int          i;
        int          n;
        seed       = 47221;
        errors     = 0;
        checks     = 0;
        rst        = 1'b1;
        addr       = sd_host_pkg::ARG0;
        wdata      = '0;
        cs         = 1'b0;
        rw         = 1'b0;
        resp_req   = 1'b0;
        block_req  = 1'b0;
        flip_crc   = 1'b0;
        resp_field = '0;
        chk_en     = 1'b0;
        chk_id     = 0;
        chk_name   = "";
        chk_exp    = '0;
        chk_act    = '0;
        for (i = 0; i < `SD_BLOCK_BYTES; i++) begin
            blk[i] = 8'($random(seed));
        end
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        expect_equal(1, "reset cmd_line", 32'd1, 32'(host_cmd));
        cpu_read(sd_host_pkg::CMD_STATUS, d);
        expect_equal(1, "reset status", 32'd0, 32'(d));

        arg = $random(seed);
        idx = 6'($random(seed));
        for (i = 0; i < 4; i++) begin
            cpu_write(sd_host_pkg::sd_reg_addr_e'(i), arg[8 * i +: 8]);
        end
        base = frame_count;
        cpu_write(sd_host_pkg::CMD_STATUS, {2'b00, idx});
        wait_frame(base, 1000);
        expect_equal(2, "cmd_frame trans", 32'd1, 32'(frame.trans));
        expect_equal(2, "cmd_frame index", 32'(idx), 32'(frame.index));
        expect_equal(2, "cmd_frame arg", arg, frame.arg);
        expect_equal(2, "cmd_frame crc7", 32'(frame_crc), 32'(frame.crc));
        expect_equal(2, "cmd_frame end", 32'd1, 32'(frame.stop));
        wait_status_bit(3, 1'b0, "busy to clear after transmit", 200);

        resp_field = $random(seed);
        card_transfer(1'b0, 1000);
        wait_status_bit(0, 1'b1, "resp_ready", 400);
        expect_equal(3, "response resp_ready", 32'd1, 32'(status.resp_ready));
        for (i = 0; i < 4; i++) begin
            cpu_read(sd_host_pkg::sd_reg_addr_e'(i), d);
            expect_equal(3, "response arg byte", 32'(resp_field[8 * i +: 8]), 32'(d));
        end
        cpu_read(sd_host_pkg::CMD_STATUS, d);
        expect_equal(3, "response resp_ready after read", 32'd0, 32'(d[0]));

        flip_crc = 1'b0;
        card_transfer(1'b1, 20000);
        wait_status_bit(1, 1'b1, "data_ready on a good block", 400);
        expect_equal(4, "block crc_err", 32'd0, 32'(status.crc_err));
        for (i = 0; i < `SD_BLOCK_BYTES; i++) begin
            cpu_read(sd_host_pkg::DATA, d);
            expect_equal(4, "block byte", 32'(blk[i]), 32'(d));
        end

        // one crc bit flipped by the card
        flip_crc = 1'b1;
        card_transfer(1'b1, 20000);
        wait_status_bit(1, 1'b1, "data_ready on a bad block", 400);
        expect_equal(5, "bad_block data_ready", 32'd1, 32'(status.data_ready));
        expect_equal(5, "bad_block crc_err", 32'd1, 32'(status.crc_err));

        arg = $random(seed);
        idx = 6'($random(seed));
        for (i = 0; i < 4; i++) begin
            cpu_write(sd_host_pkg::sd_reg_addr_e'(i), arg[8 * i +: 8]);
        end
        base = frame_count;
        cpu_write(sd_host_pkg::CMD_STATUS, {2'b00, idx});
        cpu_read(sd_host_pkg::CMD_STATUS, d);
        status = d;
        expect_equal(6, "busy_write busy", 32'd1, 32'(status.busy));
        cpu_write(sd_host_pkg::CMD_STATUS, {2'b00, ~idx});
        wait_frame(base, 1000);
        wait_status_bit(3, 1'b0, "busy to clear after the first command", 200);
        // give a second frame time to appear if one had been started
        n = 0;
        while (frame_count - base < 2 && n < 400) begin
            @(posedge clk);
            #1;
            n++;
        end
        expect_equal(6, "busy_write frame count", 32'd1, 32'(frame_count - base));
        expect_equal(6, "busy_write index", 32'(idx), 32'(frame.index));
        expect_equal(6, "busy_write arg", arg, frame.arg);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sd_host_top.f
+incdir+design
design/sd_bus_pkg.sv
design/sd_host_pkg.sv
design/sd_crc7.sv
design/sd_controller.sv
design/sd_data_rx.sv
design/sd_rx_buffer.sv
design/sd_host_top.sv
tb/sd_card_model.sv
tb/tb_sd_host_top.sv

//--- Makefile
# Verilator build and run for the SD host testbench

SIM       ?= verilator
TOP       ?= tb_sd_host_top
FILELIST  ?= sd_host_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
SIM_FLAGS ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard design/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF '*** TEST PASSED ***' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
